// File: rtl/dbg_pkg.sv
// Debug port shared definitions
package dbg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and address decode
	////////////////////////////////////////////////////////////////////////////

	localparam int DATA_W = 32;
	localparam int REG_IDX_W = 5;
	// Word address bit, set for control/status
	localparam int CTRL_SEL_BIT = 5;

	// Command bits in the control word
	localparam int RESET_BIT = 6;
	localparam int STEP_BIT = 8;
	localparam int HALT_BIT = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Status-only positions
	localparam int STATUS_IRQ_BIT = 7;
	localparam int STATUS_STALL_BIT = 9;
	localparam int STATUS_CC_LSB = 11;
	localparam int STATUS_BREAK_BIT = 14;
	localparam int STATUS_IRQ_COPY_BIT = 16;

	typedef logic [DATA_W-1:0] dbg_word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Control word as written by the host
	// Field widths follow the command bit positions above
	typedef struct packed {
		logic [DATA_W-CLEAR_CACHE_BIT-2:0] rsvd_hi;
		logic clear_cache;
		logic halt;
		logic [HALT_BIT-STEP_BIT-2:0] rsvd_mid;
		logic step;
		logic [STEP_BIT-RESET_BIT-2:0] rsvd_lo;
		logic reset;
		logic [RESET_BIT-1:0] rsvd_idx;
	} dbg_cmd_t;

	// Same write data, either a register value or a command
	typedef union packed {
		dbg_word_t raw;
		dbg_cmd_t cmd;
	} dbg_word_u;

endpackage

// File: rtl/dbg_skid_buffer.sv
// AXI request skid buffer
module dbg_skid_buffer #(
	parameter int DW = 8
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Upstream side
	input logic i_valid,
	output logic o_ready,
	input logic [DW-1:0] i_data,
	// Downstream side
	output logic o_valid,
	input logic i_ready,
	output logic [DW-1:0] o_data
);

	// One held item
	logic r_valid;
	logic [DW-1:0] r_data;

	////////////////////////////////////////////////////////////////////////////
	// Hold state
	////////////////////////////////////////////////////////////////////////////

	// Set when an item arrives that downstream refuses
	// Cleared once downstream takes the held item
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (!r_valid)
			r_valid <= i_valid && !i_ready;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture only on a stall
	// Back to zero when drained, saves toggling
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!r_valid && i_valid && !i_ready)
			r_data <= i_data;
		else if (i_ready)
			r_data <= '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	// Ready drops the cycle after a stall
	assign o_ready = !r_valid;

	// Held item goes out ahead of new input
	assign o_valid = r_valid || i_valid;

	// Idle output is zero
	always_comb
	begin
		if (r_valid)
			o_data = r_data;
		else if (i_valid)
			o_data = i_data;
		else
			o_data = '0;
	end

endmodule

// File: rtl/dbg_write_path.sv
// Debug write path
module dbg_write_path (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Write address, word address
	input logic i_aw_valid,
	output logic o_aw_ready,
	input logic [dbg_pkg::CTRL_SEL_BIT:0] i_aw_addr,
	// Write data
	input logic i_w_valid,
	output logic o_w_ready,
	input dbg_pkg::dbg_word_u i_w_data,
	input logic [dbg_pkg::DATA_W/8-1:0] i_w_strb,
	// Core register write port
	input logic i_cpu_dbg_stall,
	output logic o_cpu_dbg_we,
	output dbg_pkg::reg_idx_t o_cpu_dbg_wreg,
	output dbg_pkg::dbg_word_t o_cpu_dbg_wdata,
	// To the command controller
	output logic o_cmd_write,
	output logic [1:0] o_cmd_strb,
	output dbg_pkg::dbg_word_u o_cmd_word,
	output logic o_reg_write_taken,
	// Write response
	output logic o_bvalid,
	input logic i_bready
);

	logic is_ctrl;
	logic has_strb;
	logic core_free;
	logic write_take;
	logic reg_load;

	////////////////////////////////////////////////////////////////////////////
	// Take decision
	////////////////////////////////////////////////////////////////////////////

	assign is_ctrl = i_aw_addr[dbg_pkg::CTRL_SEL_BIT];
	assign has_strb = |i_w_strb;

	// Register port free, or pending write retires this cycle
	assign core_free = !o_cpu_dbg_we || !i_cpu_dbg_stall;

	// Both channels present, response slot open
	// Stalled core blocks register writes only
	assign write_take = i_aw_valid && i_w_valid
		&& (!o_bvalid || i_bready)
		&& (is_ctrl || !has_strb || core_free);

	// Address and data leave together
	assign o_aw_ready = write_take;
	assign o_w_ready = write_take;

	// Real register write, all strobes clear is a no-op
	assign reg_load = write_take && !is_ctrl && has_strb;

	////////////////////////////////////////////////////////////////////////////
	// Core register write
	////////////////////////////////////////////////////////////////////////////

	// Held until the core drops its stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_cpu_dbg_we <= 1'b0;
		else if (core_free)
			o_cpu_dbg_we <= reg_load;
	end

	// Index and data frozen with the strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (core_free)
		begin
			o_cpu_dbg_wreg <= reg_load ? i_aw_addr[dbg_pkg::REG_IDX_W-1:0] : '0;
			o_cpu_dbg_wdata <= reg_load ? i_w_data.raw : '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Commands and response
	////////////////////////////////////////////////////////////////////////////

	// Same-cycle command strobe
	assign o_cmd_write = write_take && is_ctrl;
	// Bytes 0 and 1 carry the command bits
	assign o_cmd_strb = i_w_strb[1:0];
	assign o_cmd_word = i_w_data;
	// Controller halts the core on this
	assign o_reg_write_taken = reg_load;

	// Every take answers, held until the host accepts
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_take)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

endmodule

// File: rtl/dbg_read_path.sv
// Debug read path
module dbg_read_path (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Read address, word address
	input logic i_ar_valid,
	output logic o_ar_ready,
	input logic [dbg_pkg::CTRL_SEL_BIT:0] i_ar_addr,
	// Core register read port
	output dbg_pkg::reg_idx_t o_cpu_dbg_rreg,
	input dbg_pkg::dbg_word_t i_cpu_dbg_data,
	// Control/status word
	input dbg_pkg::dbg_word_t i_status,
	// Read data
	output logic o_rvalid,
	input logic i_rready,
	output dbg_pkg::dbg_word_t o_rdata
);

	logic is_ctrl;
	logic read_take;
	// Core data due next cycle
	logic reg_pending;

	////////////////////////////////////////////////////////////////////////////
	// Take decision
	////////////////////////////////////////////////////////////////////////////

	assign is_ctrl = i_ar_addr[dbg_pkg::CTRL_SEL_BIT];

	// One read in flight, data slot must be free
	assign read_take = i_ar_valid && !reg_pending
		&& (!o_rvalid || i_rready);

	assign o_ar_ready = read_take;

	// Index only while taking, else zero
	assign o_cpu_dbg_rreg = read_take ? i_ar_addr[dbg_pkg::REG_IDX_W-1:0] : '0;

	// Register read waits a cycle for the core
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			reg_pending <= 1'b0;
		else
			reg_pending <= read_take && !is_ctrl;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read response
	////////////////////////////////////////////////////////////////////////////

	// Status answers one cycle after the take
	// Core register two cycles after
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_take && is_ctrl) || reg_pending;
	end

	// Data frozen while the host holds off
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
		begin
			if (reg_pending)
				o_rdata <= i_cpu_dbg_data;
			else if (read_take && is_ctrl)
				o_rdata <= i_status;
			else
				o_rdata <= '0;
		end
	end

endmodule

// File: rtl/dbg_cpu_ctrl.sv
// Core command controller
module dbg_cpu_ctrl #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// From the write path
	input logic i_cmd_write,
	input logic [1:0] i_cmd_strb,
	input dbg_pkg::dbg_word_u i_cmd_word,
	input logic i_reg_write_taken,
	// From the core
	input logic i_cpu_dbg_stall,
	input logic i_cpu_break,
	input logic [2:0] i_cpu_dbg_cc,
	input logic i_interrupt,
	// To the core
	output logic o_cpu_reset,
	output logic o_cpu_halt,
	output logic o_cpu_clear_cache,
	// To the read path
	output dbg_pkg::dbg_word_t o_status
);

	localparam int CNT_W = (RESET_DURATION > 0) ? $clog2(RESET_DURATION + 1) : 1;

	logic [CNT_W-1:0] hold_count;
	logic reset_hold;
	logic cmd_reset;
	logic cmd_halt;
	logic cmd_step;
	logic cmd_clear_cache;
	// Command write with the matching strobe byte
	logic cmd_lo;
	logic cmd_hi;

	assign cmd_lo = i_cmd_write && i_cmd_strb[0];
	assign cmd_hi = i_cmd_write && i_cmd_strb[1];

	////////////////////////////////////////////////////////////////////////////
	// Reset
	////////////////////////////////////////////////////////////////////////////

	// Power-on hold, counts down after bus reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			hold_count <= CNT_W'(RESET_DURATION);
		else if (hold_count != '0)
			hold_count <= hold_count - 1'b1;
	end

	assign reset_hold = (hold_count != '0);

	// Free-running core resets itself on a break
	// Host reset is a single cycle pulse
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cmd_reset <= 1'b1;
		else if (reset_hold || (i_cpu_break && !START_HALTED))
			cmd_reset <= 1'b1;
		else
			cmd_reset <= cmd_lo && i_cmd_word.cmd.reset;
	end

	////////////////////////////////////////////////////////////////////////////
	// Halt, step and clear cache
	////////////////////////////////////////////////////////////////////////////

	// Later assignments win, so halt reasons override a release
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cmd_halt <= START_HALTED;
		else if (cmd_reset && START_HALTED)
			cmd_halt <= 1'b1;
		else
		begin
			// Release, or let one step through
			if (cmd_hi && !i_cpu_dbg_stall
					&& (!i_cmd_word.cmd.halt || i_cmd_word.cmd.step))
				cmd_halt <= 1'b0;
			// Break holds the core for inspection
			if (i_cpu_break && START_HALTED)
				cmd_halt <= 1'b1;
			// Plain halt request
			if (cmd_hi && i_cmd_word.cmd.halt && !i_cmd_word.cmd.step)
				cmd_halt <= 1'b1;
			// Core must stop before its registers change
			if (i_reg_write_taken)
				cmd_halt <= 1'b1;
			// Step or cache clear finished
			if (cmd_step || cmd_clear_cache)
				cmd_halt <= 1'b1;
			if (cmd_hi && i_cmd_word.cmd.clear_cache)
				cmd_halt <= 1'b1;
		end
	end

	// Dropped once the core has moved
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cmd_step <= 1'b0;
		else if (cmd_hi && i_cmd_word.cmd.step)
			cmd_step <= 1'b1;
		else if (!i_cpu_dbg_stall)
			cmd_step <= 1'b0;
	end

	// Needs halt in the same word
	// Held until the core is halted and idle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear_cache <= 1'b0;
		else if (cmd_hi && i_cmd_word.cmd.clear_cache && i_cmd_word.cmd.halt)
			cmd_clear_cache <= 1'b1;
		else if (cmd_halt && !i_cpu_dbg_stall)
			cmd_clear_cache <= 1'b0;
	end

	assign o_cpu_reset = cmd_reset;
	assign o_cpu_halt = cmd_halt;
	assign o_cpu_clear_cache = cmd_clear_cache;

	////////////////////////////////////////////////////////////////////////////
	// Status word
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		o_status = '0;
		o_status[dbg_pkg::STATUS_IRQ_COPY_BIT] = i_interrupt;
		o_status[dbg_pkg::STATUS_BREAK_BIT] = i_cpu_break;
		o_status[dbg_pkg::STATUS_CC_LSB +: 3] = i_cpu_dbg_cc;
		o_status[dbg_pkg::HALT_BIT] = cmd_halt;
		// Set when the core is not stalled
		o_status[dbg_pkg::STATUS_STALL_BIT] = !i_cpu_dbg_stall;
		o_status[dbg_pkg::STEP_BIT] = cmd_step;
		o_status[dbg_pkg::STATUS_IRQ_BIT] = i_interrupt;
		o_status[dbg_pkg::RESET_BIT] = cmd_reset;
	end

endmodule

// File: rtl/dbg_axil.sv
// AXI-lite core debug port
module dbg_axil #(
	parameter int C_DBG_ADDR_WIDTH = 8,
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Write address
	input logic i_dbg_awvalid,
	output logic o_dbg_awready,
	input logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_awaddr,
	// Write data
	input logic i_dbg_wvalid,
	output logic o_dbg_wready,
	input logic [dbg_pkg::DATA_W-1:0] i_dbg_wdata,
	input logic [dbg_pkg::DATA_W/8-1:0] i_dbg_wstrb,
	// Write response
	output logic o_dbg_bvalid,
	input logic i_dbg_bready,
	output logic [1:0] o_dbg_bresp,
	// Read address
	input logic i_dbg_arvalid,
	output logic o_dbg_arready,
	input logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_araddr,
	// Read data
	output logic o_dbg_rvalid,
	input logic i_dbg_rready,
	output logic [dbg_pkg::DATA_W-1:0] o_dbg_rdata,
	output logic [1:0] o_dbg_rresp,
	// Core debug side
	output logic o_cpu_reset,
	output logic o_cpu_halt,
	output logic o_cpu_clear_cache,
	output logic o_cpu_dbg_we,
	output logic [dbg_pkg::REG_IDX_W-1:0] o_cpu_dbg_wreg,
	output logic [dbg_pkg::DATA_W-1:0] o_cpu_dbg_wdata,
	output logic [dbg_pkg::REG_IDX_W-1:0] o_cpu_dbg_rreg,
	input logic i_cpu_dbg_stall,
	input logic [dbg_pkg::DATA_W-1:0] i_cpu_dbg_data,
	input logic [2:0] i_cpu_dbg_cc,
	input logic i_cpu_break,
	input logic i_interrupt
);

	// Word address, byte lanes dropped
	localparam int WA_W = C_DBG_ADDR_WIDTH - 2;
	localparam int WSKD_W = dbg_pkg::DATA_W + dbg_pkg::DATA_W / 8;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic awskd_valid, wskd_valid, arskd_valid;
	logic write_ready, wdata_ready, read_ready;
	logic [WA_W-1:0] awskd_addr, arskd_addr;
	// Write data above, strobes in the low nibble
	logic [WSKD_W-1:0] wskd_bus;
	logic cmd_write, reg_write_taken;
	logic [1:0] cmd_strb;
	dbg_pkg::dbg_word_u cmd_word;
	dbg_pkg::dbg_word_t status;

	////////////////////////////////////////////////////////////////////////////
	// Request skid buffers
	////////////////////////////////////////////////////////////////////////////

	dbg_skid_buffer #(.DW(WA_W)) u_aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_awvalid), .o_ready(o_dbg_awready),
		.i_data(i_dbg_awaddr[C_DBG_ADDR_WIDTH-1:2]),
		.o_valid(awskd_valid), .i_ready(write_ready), .o_data(awskd_addr)
	);

	dbg_skid_buffer #(.DW(WSKD_W)) u_w_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_wvalid), .o_ready(o_dbg_wready),
		.i_data({i_dbg_wdata, i_dbg_wstrb}),
		.o_valid(wskd_valid), .i_ready(wdata_ready), .o_data(wskd_bus)
	);

	dbg_skid_buffer #(.DW(WA_W)) u_ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_arvalid), .o_ready(o_dbg_arready),
		.i_data(i_dbg_araddr[C_DBG_ADDR_WIDTH-1:2]),
		.o_valid(arskd_valid), .i_ready(read_ready), .o_data(arskd_addr)
	);

	////////////////////////////////////////////////////////////////////////////
	// Consumers
	////////////////////////////////////////////////////////////////////////////

	// Write path takes both channels together
	dbg_write_path u_write_path (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_aw_valid(awskd_valid), .o_aw_ready(write_ready),
		.i_aw_addr(awskd_addr[dbg_pkg::CTRL_SEL_BIT:0]),
		.i_w_valid(wskd_valid), .o_w_ready(wdata_ready),
		.i_w_data(wskd_bus[WSKD_W-1:dbg_pkg::DATA_W/8]),
		.i_w_strb(wskd_bus[dbg_pkg::DATA_W/8-1:0]),
		.i_cpu_dbg_stall(i_cpu_dbg_stall), .o_cpu_dbg_we(o_cpu_dbg_we),
		.o_cpu_dbg_wreg(o_cpu_dbg_wreg), .o_cpu_dbg_wdata(o_cpu_dbg_wdata),
		.o_cmd_write(cmd_write), .o_cmd_strb(cmd_strb), .o_cmd_word(cmd_word),
		.o_reg_write_taken(reg_write_taken),
		.o_bvalid(o_dbg_bvalid), .i_bready(i_dbg_bready)
	);

	dbg_read_path u_read_path (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_ar_valid(arskd_valid), .o_ar_ready(read_ready),
		.i_ar_addr(arskd_addr[dbg_pkg::CTRL_SEL_BIT:0]),
		.o_cpu_dbg_rreg(o_cpu_dbg_rreg), .i_cpu_dbg_data(i_cpu_dbg_data),
		.i_status(status),
		.o_rvalid(o_dbg_rvalid), .i_rready(i_dbg_rready), .o_rdata(o_dbg_rdata)
	);

	dbg_cpu_ctrl #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) u_cpu_ctrl (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cmd_write(cmd_write), .i_cmd_strb(cmd_strb), .i_cmd_word(cmd_word),
		.i_reg_write_taken(reg_write_taken),
		.i_cpu_dbg_stall(i_cpu_dbg_stall), .i_cpu_break(i_cpu_break),
		.i_cpu_dbg_cc(i_cpu_dbg_cc), .i_interrupt(i_interrupt),
		.o_cpu_reset(o_cpu_reset), .o_cpu_halt(o_cpu_halt),
		.o_cpu_clear_cache(o_cpu_clear_cache), .o_status(status)
	);

	// Every access succeeds
	assign o_dbg_bresp = RESP_OKAY;
	assign o_dbg_rresp = RESP_OKAY;

endmodule

// File: sim/tb_dbg_tasks.svh
// Debug port bus and test tasks
`ifndef TB_DBG_TASKS_SVH
`define TB_DBG_TASKS_SVH

	task automatic stop_with_error(string msg);
		error_count++;
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic compare_word(string name, dbg_pkg::dbg_word_t exp, dbg_pkg::dbg_word_t act);
		if (exp !== act)
			stop_with_error($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic compare_bit(string name, logic exp, logic act);
		if (exp !== act)
			stop_with_error($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
	endtask

	task automatic compare_reg(string name, dbg_pkg::reg_idx_t exp, dbg_pkg::reg_idx_t act);
		if (exp !== act)
			stop_with_error($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
	endtask

	function automatic logic [7:0] reg_addr(dbg_pkg::reg_idx_t idx);
		return {1'b0, idx, 2'b00};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks, entered and left 1 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic send_write(logic [7:0] addr, dbg_pkg::dbg_word_t data, logic [3:0] strb);
		int waited;
		waited = 0;
		i_dbg_awvalid = 1'b1;
		i_dbg_awaddr = addr;
		i_dbg_wvalid = 1'b1;
		i_dbg_wdata = data;
		i_dbg_wstrb = strb;
		@(negedge S_AXI_ACLK);
		while (!(o_dbg_awready && o_dbg_wready))
		begin
			if (++waited > 50)
				stop_with_error("Write request was never accepted");
			@(negedge S_AXI_ACLK);
		end
		@(posedge S_AXI_ACLK);
		#1 {i_dbg_awvalid, i_dbg_wvalid} = 2'b00;
	endtask

	task automatic wait_bresp();
		int waited;
		waited = 0;
		i_dbg_bready = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!o_dbg_bvalid)
		begin
			if (++waited > 50)
				stop_with_error("Write response never arrived");
			@(negedge S_AXI_ACLK);
		end
		// OKAY on every write
		compare_word("bresp", 32'd0, dbg_pkg::dbg_word_t'(o_dbg_bresp));
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	task automatic write_word(logic [7:0] addr, dbg_pkg::dbg_word_t data, logic [3:0] strb);
		send_write(addr, data, strb);
		wait_bresp();
	endtask

	task automatic send_read(logic [7:0] addr);
		int waited;
		waited = 0;
		i_dbg_arvalid = 1'b1;
		i_dbg_araddr = addr;
		@(negedge S_AXI_ACLK);
		while (!o_dbg_arready)
		begin
			if (++waited > 50)
				stop_with_error("Read request was never accepted");
			@(negedge S_AXI_ACLK);
		end
		@(posedge S_AXI_ACLK);
		#1 i_dbg_arvalid = 1'b0;
	endtask

	// Latency counts cycles from the address handshake
	task automatic get_rdata(output dbg_pkg::dbg_word_t data, output int latency);
		i_dbg_rready = 1'b1;
		latency = 1;
		@(negedge S_AXI_ACLK);
		while (!o_dbg_rvalid)
		begin
			if (++latency > 50)
				stop_with_error("Read data never arrived");
			@(negedge S_AXI_ACLK);
		end
		data = o_dbg_rdata;
		compare_word("rresp", 32'd0, dbg_pkg::dbg_word_t'(o_dbg_rresp));
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	task automatic read_word(logic [7:0] addr, output dbg_pkg::dbg_word_t data, output int lat);
		send_read(addr);
		get_rdata(data, lat);
	endtask

	task automatic wait_core_writes(int count);
		int waited;
		waited = 0;
		while (core_write_count < count)
		begin
			if (++waited > 50)
				stop_with_error("Core register write never completed");
			@(posedge S_AXI_ACLK);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_hold();
		dbg_pkg::dbg_word_t st;
		int lat;
		int waited;
		waited = 0;
		read_word(CTRL_ADDR, st, lat);
		compare_bit("reset_hold_status", 1'b1, st[dbg_pkg::RESET_BIT]);
		compare_bit("reset_hold_halt", 1'b0, o_cpu_halt);
		while (o_cpu_reset)
		begin
			if (++waited > 4 * RESET_DURATION)
				stop_with_error("Core reset was never released");
			@(negedge S_AXI_ACLK);
		end
		if (reset_high_cycles < RESET_DURATION || reset_high_cycles > RESET_DURATION + 1)
			stop_with_error($sformatf("Core reset was held for %0d cycles", reset_high_cycles));
		@(posedge S_AXI_ACLK);
		#1;
		read_word(CTRL_ADDR, st, lat);
		compare_bit("reset_done_status", 1'b0, st[dbg_pkg::RESET_BIT]);
		compare_bit("reset_done_halt", 1'b0, o_cpu_halt);
	endtask

	task automatic test_halt_release();
		dbg_pkg::dbg_word_t st;
		int lat;
		write_word(CTRL_ADDR, 32'h1 << dbg_pkg::HALT_BIT, 4'b0010);
		compare_bit("halt_cmd", 1'b1, o_cpu_halt);
		read_word(CTRL_ADDR, st, lat);
		compare_bit("halt_status", 1'b1, st[dbg_pkg::HALT_BIT]);
		compare_word("status_latency", 32'd1, dbg_pkg::dbg_word_t'(lat));
		write_word(CTRL_ADDR, '0, 4'b0010);
		compare_bit("release_cmd", 1'b0, o_cpu_halt);
		read_word(CTRL_ADDR, st, lat);
		compare_bit("release_status", 1'b0, st[dbg_pkg::HALT_BIT]);
	endtask

	task automatic test_reg_write_read();
		dbg_pkg::reg_idx_t idx;
		dbg_pkg::dbg_word_t data;
		int base;
		int lat;
		base = core_write_count;
		for (int i = 0; i < 8; i++)
		begin
			idx = dbg_pkg::reg_idx_t'(lfsr_bits(5));
			data = lfsr_bits(32);
			exp_regs[idx] = data;
			written[idx] = 1'b1;
			write_word(reg_addr(idx), data, 4'hf);
			wait_core_writes(base + i + 1);
			compare_reg("reg_write_index", idx, last_wreg);
			compare_word("reg_write_data", data, last_wdata);
			compare_bit("halted_before_write", 1'b1, halt_at_write);
		end
		for (int k = 0; k < 32; k++)
		begin
			if (written[k])
			begin
				read_word(reg_addr(dbg_pkg::reg_idx_t'(k)), data, lat);
				compare_word("reg_readback", exp_regs[k], data);
				compare_word("reg_read_latency", 32'd2, dbg_pkg::dbg_word_t'(lat));
			end
		end
	endtask

	task automatic test_step_clear_cache();
		halt_low_cycles = 0;
		write_word(CTRL_ADDR, 32'h1 << dbg_pkg::STEP_BIT, 4'b0010);
		repeat (4) @(posedge S_AXI_ACLK);
		#1;
		if (halt_low_cycles == 0)
			stop_with_error("Step command never released the core");
		compare_bit("step_rehalt", 1'b1, o_cpu_halt);
		clear_cache_cycles = 0;
		write_word(CTRL_ADDR, (32'h1 << dbg_pkg::HALT_BIT)
			| (32'h1 << dbg_pkg::CLEAR_CACHE_BIT), 4'b0010);
		repeat (4) @(posedge S_AXI_ACLK);
		#1;
		if (clear_cache_cycles == 0)
			stop_with_error("Clear-cache command never reached the core");
		compare_bit("clear_cache_done", 1'b0, o_cpu_clear_cache);
		compare_bit("clear_cache_halt", 1'b1, o_cpu_halt);
	endtask

	task automatic test_break_status();
		dbg_pkg::dbg_word_t st;
		int lat;
		i_cpu_break = 1'b1;
		i_cpu_dbg_cc = 3'b101;
		i_interrupt = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		// Free-running build resets on a break
		compare_bit("break_reset", 1'b1, o_cpu_reset);
		read_word(CTRL_ADDR, st, lat);
		compare_bit("status_break", 1'b1, st[dbg_pkg::STATUS_BREAK_BIT]);
		compare_word("status_cc", 32'd5, dbg_pkg::dbg_word_t'(st[dbg_pkg::STATUS_CC_LSB +: 3]));
		compare_bit("status_irq", 1'b1, st[dbg_pkg::STATUS_IRQ_BIT]);
		compare_bit("status_irq_copy", 1'b1, st[dbg_pkg::STATUS_IRQ_COPY_BIT]);
		compare_bit("status_reset", 1'b1, st[dbg_pkg::RESET_BIT]);
		{i_cpu_break, i_interrupt} = 2'b00;
		i_cpu_dbg_cc = '0;
		@(posedge S_AXI_ACLK);
		#1;
		compare_bit("break_reset_end", 1'b0, o_cpu_reset);
		read_word(CTRL_ADDR, st, lat);
		compare_bit("status_break_end", 1'b0, st[dbg_pkg::STATUS_BREAK_BIT]);
		compare_bit("status_irq_end", 1'b0, st[dbg_pkg::STATUS_IRQ_BIT]);
	endtask

	task automatic test_back_pressure();
		dbg_pkg::dbg_word_t d1, d2, held, rd;
		int base, count, waited, lat;
		base = core_write_count;
		d1 = lfsr_bits(32);
		d2 = lfsr_bits(32);
		i_dbg_bready = 1'b0;
		send_write(reg_addr(5'd3), d1, 4'hf);
		waited = 0;
		while (!o_dbg_bvalid)
		begin
			if (++waited > 50)
				stop_with_error("Write response never arrived under back-pressure");
			@(negedge S_AXI_ACLK);
		end
		repeat (4)
		begin
			@(negedge S_AXI_ACLK);
			compare_bit("bvalid_held", 1'b1, o_dbg_bvalid);
		end
		@(posedge S_AXI_ACLK);
		#1;
		send_write(reg_addr(5'd9), d2, 4'hf);
		@(negedge S_AXI_ACLK);
		compare_bit("aw_skid_full", 1'b0, o_dbg_awready);
		@(posedge S_AXI_ACLK);
		#1 i_dbg_bready = 1'b1;
		count = 0;
		waited = 0;
		while (count < 2)
		begin
			@(negedge S_AXI_ACLK);
			if (o_dbg_bvalid)
				count++;
			if (++waited > 50)
				stop_with_error("Second write response was lost");
		end
		@(posedge S_AXI_ACLK);
		#1;
		// Both responses accepted, nothing left
		compare_bit("bvalid_drained", 1'b0, o_dbg_bvalid);
		wait_core_writes(base + 2);
		compare_word("bp_write_first", d1, core_regs[3]);
		compare_word("bp_write_second", d2, core_regs[9]);
		// Read side, status held while the host stalls
		i_dbg_rready = 1'b0;
		send_read(CTRL_ADDR);
		@(negedge S_AXI_ACLK);
		compare_bit("rvalid_first", 1'b1, o_dbg_rvalid);
		held = o_dbg_rdata;
		compare_bit("held_status_halt", 1'b1, held[dbg_pkg::HALT_BIT]);
		@(posedge S_AXI_ACLK);
		#1;
		send_read(reg_addr(5'd9));
		repeat (3)
		begin
			@(negedge S_AXI_ACLK);
			compare_bit("ar_skid_full", 1'b0, o_dbg_arready);
			compare_bit("rvalid_held", 1'b1, o_dbg_rvalid);
			compare_word("rdata_stable", held, o_dbg_rdata);
		end
		@(posedge S_AXI_ACLK);
		#1 i_dbg_rready = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		get_rdata(rd, lat);
		compare_word("bp_read_second", d2, rd);
	endtask

`endif

// File: sim/tb_dbg_axil.sv
// Debug port testbench
module tb_dbg_axil;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int C_DBG_ADDR_WIDTH = 8;
	localparam int RESET_DURATION = 10;
	localparam bit START_HALTED = 1'b0;
	localparam int NUM_TESTS = 6;
	// Per-test budget plus reset and hold
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + RESET_DURATION + 4;
	localparam logic [7:0] CTRL_ADDR = 8'h80;

	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	logic i_dbg_awvalid, o_dbg_awready;
	logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_awaddr;
	logic i_dbg_wvalid, o_dbg_wready;
	logic [31:0] i_dbg_wdata;
	logic [3:0] i_dbg_wstrb;
	logic o_dbg_bvalid, i_dbg_bready;
	logic [1:0] o_dbg_bresp;
	logic i_dbg_arvalid, o_dbg_arready;
	logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_araddr;
	logic o_dbg_rvalid, i_dbg_rready;
	logic [31:0] o_dbg_rdata;
	logic [1:0] o_dbg_rresp;
	logic o_cpu_reset, o_cpu_halt, o_cpu_clear_cache, o_cpu_dbg_we;
	logic [4:0] o_cpu_dbg_wreg, o_cpu_dbg_rreg;
	logic [31:0] o_cpu_dbg_wdata;
	logic i_cpu_dbg_stall;
	logic [31:0] i_cpu_dbg_data;
	logic [2:0] i_cpu_dbg_cc;
	logic i_cpu_break, i_interrupt;

	// Core model state
	dbg_pkg::dbg_word_t core_regs [32];
	int core_write_count = 0;
	dbg_pkg::reg_idx_t last_wreg;
	dbg_pkg::dbg_word_t last_wdata;
	logic halt_at_write;

	// Expected register contents
	dbg_pkg::dbg_word_t exp_regs [32];
	logic written [32];

	// Cycle counters kept at the falling edge
	int reset_high_cycles = 0;
	int halt_low_cycles = 0;
	int clear_cache_cycles = 0;
	int error_count = 0;
	logic [31:0] lfsr_state = 32'h1845_6eac;

	dbg_axil #(
		.C_DBG_ADDR_WIDTH(C_DBG_ADDR_WIDTH),
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) i_dbg_axil (.*);

	always #2 S_AXI_ACLK = !S_AXI_ACLK;

	////////////////////////////////////////////////////////////////////////////
	// Core model
	////////////////////////////////////////////////////////////////////////////

	// Running core stalls debug writes, read data one cycle late
	always @(posedge S_AXI_ACLK)
	begin
		i_cpu_dbg_stall <= #1 !o_cpu_halt;
		i_cpu_dbg_data <= #1 core_regs[o_cpu_dbg_rreg];
		if (o_cpu_dbg_we && !i_cpu_dbg_stall)
		begin
			core_regs[o_cpu_dbg_wreg] <= o_cpu_dbg_wdata;
			last_wreg <= o_cpu_dbg_wreg;
			last_wdata <= o_cpu_dbg_wdata;
			halt_at_write <= o_cpu_halt;
			core_write_count <= core_write_count + 1;
		end
	end

	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN && o_cpu_reset)
			reset_high_cycles++;
		if (!o_cpu_halt)
			halt_low_cycles++;
		if (o_cpu_clear_cache)
			clear_cache_cycles++;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic dbg_pkg::dbg_word_t lfsr_bits(int n);
		dbg_pkg::dbg_word_t v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], lfsr_next_bit()};
		return v;
	endfunction

`include "tb_dbg_tasks.svh"

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge S_AXI_ACLK);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$fatal(1, "Simulation stopped by watchdog");
	end

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		{i_dbg_awvalid, i_dbg_wvalid, i_dbg_arvalid} = '0;
		{i_dbg_bready, i_dbg_rready} = 2'b11;
		i_dbg_awaddr = '0;
		i_dbg_araddr = '0;
		i_dbg_wdata = '0;
		i_dbg_wstrb = '0;
		i_cpu_dbg_stall = 1'b1;
		i_cpu_dbg_data = '0;
		i_cpu_dbg_cc = '0;
		{i_cpu_break, i_interrupt} = 2'b00;
		for (int k = 0; k < 32; k++)
		begin
			core_regs[k] = '0;
			exp_regs[k] = '0;
			written[k] = 1'b0;
		end
		repeat (4) @(posedge S_AXI_ACLK);
		#1 S_AXI_ARESETN = 1'b1;
		test_reset_hold();
		test_halt_release();
		test_reg_write_read();
		test_step_clear_cache();
		test_break_status();
		test_back_pressure();
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: src.f
rtl/dbg_pkg.sv
rtl/dbg_skid_buffer.sv
rtl/dbg_write_path.sv
rtl/dbg_read_path.sv
rtl/dbg_cpu_ctrl.sv
rtl/dbg_axil.sv
+incdir+sim
sim/tb_dbg_axil.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the debug port testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_dbg_axil -o tb_dbg_axil -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/tb_dbg_axil 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test completed successfully" <<< "$sim_output"; then
	exit 0
else
	echo "Pass line not found in simulation output"
	exit 1
fi
